// File: src/modsq_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Modular squaring loop, shared sizes and types
// Digit layout, product word layout and FSM encodings
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package modsq_pkg;

   // Operand and result digits, 4 non-redundant plus one redundant top digit
   localparam int NUM_ELEMENTS = 5;
   localparam int WORD_LEN     = 16;
   localparam int BIT_LEN      = 17;

   // Square of the operand as 16-bit words
   localparam int PROD_WORDS   = 11;
   // Words 5 to 10 are folded back through the tables
   localparam int UPPER_WORDS  = 6;
   localparam int LOOKUP_WIDTH = 8;

   // 5 products of 34 bits fit in a column
   localparam int COL_LEN      = 37;
   // 16-bit word plus twelve 16-bit table words
   localparam int ACC_LEN      = 24;

   localparam int MOD_LEN      = 64;
   localparam int RES_WORDS    = 4;

   typedef logic [BIT_LEN-1:0]      digit_t;
   typedef logic [WORD_LEN-1:0]     word_t;
   typedef logic [COL_LEN-1:0]      column_t;
   typedef logic [ACC_LEN-1:0]      acc_t;
   typedef logic [MOD_LEN-1:0]      residue_t;
   typedef logic [LOOKUP_WIDTH-1:0] half_t;

   // Odd 64-bit modulus
   localparam residue_t MODULUS_DEFAULT = 64'hC3A5_9D27_E14B_6F8D;

   typedef enum logic [1:0] {
      SQ_IDLE,
      SQ_COLUMNS,
      SQ_WAIT
   } sq_state_t;

   typedef enum logic [1:0] {
      ACC_IDLE,
      ACC_LOOKUP,
      ACC_NORMALIZE
   } acc_state_t;

endpackage

// File: src/square_column_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Column-serial squarer
// Holds the operand and emits one product column per cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module square_column_gen (
   input  logic                clk,
   input  logic                rst,
   input  logic                start,
   input  logic                valid,
   input  modsq_pkg::digit_t   sq_in  [modsq_pkg::NUM_ELEMENTS],
   input  modsq_pkg::digit_t   sq_out [modsq_pkg::NUM_ELEMENTS],
   output logic                col_valid,
   output logic                col_last,
   output modsq_pkg::column_t  col_sum
);

   localparam int NUM_COLUMNS = 2 * modsq_pkg::NUM_ELEMENTS - 1;
   localparam int CNT_W       = $clog2(NUM_COLUMNS);

   modsq_pkg::sq_state_t state;
   logic [CNT_W-1:0]     col_cnt;
   logic                 last_col;
   logic                 load_ext;
   logic                 load_loop;
   modsq_pkg::digit_t    operand [modsq_pkg::NUM_ELEMENTS];
   modsq_pkg::column_t   col_next;

   // External start only counts before the loop runs
   assign load_ext  = (state == modsq_pkg::SQ_IDLE) && start;
   assign load_loop = (state == modsq_pkg::SQ_WAIT) && valid;
   assign last_col  = (col_cnt == CNT_W'(NUM_COLUMNS - 1));

   // Column k collects every digit product with i + j == k
   always_comb begin
      col_next = '0;
      for (int i = 0; i < modsq_pkg::NUM_ELEMENTS; i++) begin
         for (int j = 0; j < modsq_pkg::NUM_ELEMENTS; j++) begin
            if (i + j == int'(col_cnt)) begin
               col_next = col_next + modsq_pkg::column_t'(operand[i]) *
                                     modsq_pkg::column_t'(operand[j]);
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= modsq_pkg::SQ_IDLE;
         col_cnt   <= '0;
         col_valid <= 1'b0;
         col_last  <= 1'b0;
      end else begin
         col_valid <= 1'b0;
         col_last  <= 1'b0;
         case (state)
            modsq_pkg::SQ_IDLE: begin
               if (load_ext) begin
                  state <= modsq_pkg::SQ_COLUMNS;
               end
            end
            modsq_pkg::SQ_COLUMNS: begin
               col_valid <= 1'b1;
               col_last  <= last_col;
               if (last_col) begin
                  col_cnt <= '0;
                  state   <= modsq_pkg::SQ_WAIT;
               end else begin
                  col_cnt <= col_cnt + 1'b1;
               end
            end
            modsq_pkg::SQ_WAIT: begin
               // Next square starts from the residue just produced
               if (load_loop) begin
                  state <= modsq_pkg::SQ_COLUMNS;
               end
            end
            default: state <= modsq_pkg::SQ_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (load_ext) begin
         operand <= sq_in;
      end else if (load_loop) begin
         operand <= sq_out;
      end
      if (state == modsq_pkg::SQ_COLUMNS) begin
         col_sum <= col_next;
      end
   end

endmodule

// File: src/product_column_buffer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Product word buffer
// Carry-propagates incoming columns into exact 16-bit words
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module product_column_buffer (
   input  logic                clk,
   input  logic                rst,
   input  logic                col_valid,
   input  logic                col_last,
   input  modsq_pkg::column_t  col_sum,
   output modsq_pkg::word_t    prod_words [modsq_pkg::PROD_WORDS],
   output logic                prod_ready
);

   localparam int CARRY_LEN = modsq_pkg::COL_LEN - modsq_pkg::WORD_LEN;
   localparam int IDX_W     = $clog2(modsq_pkg::PROD_WORDS);

   logic [IDX_W-1:0]     word_idx;
   logic [CARRY_LEN-1:0] carry;
   logic [CARRY_LEN-1:0] carry_in;
   logic [CARRY_LEN-1:0] carry_next;
   modsq_pkg::column_t   col_total;

   // First column of a square starts with nothing carried in
   assign carry_in   = (word_idx == '0) ? '0 : carry;
   assign col_total  = col_sum + modsq_pkg::column_t'(carry_in);
   assign carry_next = col_total[modsq_pkg::COL_LEN-1:modsq_pkg::WORD_LEN];

   always_ff @(posedge clk) begin
      if (rst) begin
         word_idx   <= '0;
         prod_ready <= 1'b0;
      end else begin
         prod_ready <= col_valid && col_last;
         if (col_valid) begin
            word_idx <= col_last ? '0 : word_idx + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (col_valid) begin
         prod_words[word_idx] <= col_total[modsq_pkg::WORD_LEN-1:0];
         carry                <= carry_next;
         // Leftover carry is the top two words of the square
         if (col_last) begin
            prod_words[modsq_pkg::PROD_WORDS-2] <=
               carry_next[modsq_pkg::WORD_LEN-1:0];
            prod_words[modsq_pkg::PROD_WORDS-1] <=
               modsq_pkg::word_t'(carry_next[CARRY_LEN-1:modsq_pkg::WORD_LEN]);
         end
      end
   end

endmodule

// File: src/reduction_lut.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reduction tables
// Residues of each byte at each upper half-word position
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module reduction_lut #(
   parameter modsq_pkg::residue_t MODULUS = modsq_pkg::MODULUS_DEFAULT
) (
   input  logic [$clog2(modsq_pkg::UPPER_WORDS)-1:0] word_sel,
   input  modsq_pkg::half_t                          lo_half,
   input  modsq_pkg::half_t                          hi_half,
   output modsq_pkg::residue_t                       lo_entry,
   output modsq_pkg::residue_t                       hi_entry
);

   localparam int LOW_WORDS = modsq_pkg::PROD_WORDS - modsq_pkg::UPPER_WORDS;
   localparam int ENTRIES   = 2 ** modsq_pkg::LOOKUP_WIDTH;

   modsq_pkg::residue_t lut_rom [modsq_pkg::UPPER_WORDS][2][ENTRIES];

   // (value << pos) mod MODULUS by repeated modular doubling
   function automatic modsq_pkg::residue_t shifted_residue(input int unsigned value,
                                                           input int unsigned pos);
      logic [modsq_pkg::MOD_LEN:0] m;
      logic [modsq_pkg::MOD_LEN:0] r;
      m = {1'b0, MODULUS};
      r = {{(modsq_pkg::MOD_LEN - 31){1'b0}}, value} % m;
      for (int unsigned s = 0; s < pos; s++) begin
         r = r << 1;
         if (r >= m) begin
            r = r - m;
         end
      end
      return r[modsq_pkg::MOD_LEN-1:0];
   endfunction

   for (genvar w = 0; w < modsq_pkg::UPPER_WORDS; w++) begin : g_word
      for (genvar h = 0; h < 2; h++) begin : g_half
         for (genvar b = 0; b < ENTRIES; b++) begin : g_byte
            localparam int unsigned POS = (LOW_WORDS + w) * modsq_pkg::WORD_LEN +
                                          h * modsq_pkg::LOOKUP_WIDTH;
            localparam modsq_pkg::residue_t ENTRY = shifted_residue(b, POS);
            assign lut_rom[w][h][b] = ENTRY;
         end
      end
   end

   // Both halves of the selected word are read in the same cycle
   assign lo_entry = lut_rom[word_sel][0][lo_half];
   assign hi_entry = lut_rom[word_sel][1][hi_half];

endmodule

// File: src/reduction_accumulator.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reduction accumulator
// Folds upper product words into the low digits by table
// lookup and partially normalizes the redundant residue
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module reduction_accumulator #(
   parameter modsq_pkg::residue_t MODULUS = modsq_pkg::MODULUS_DEFAULT
) (
   input  logic                clk,
   input  logic                rst,
   input  logic                prod_ready,
   input  modsq_pkg::word_t    prod_words [modsq_pkg::PROD_WORDS],
   output modsq_pkg::digit_t   sq_out     [modsq_pkg::NUM_ELEMENTS],
   output logic                valid
);

   localparam int LOW_WORDS = modsq_pkg::PROD_WORDS - modsq_pkg::UPPER_WORDS;
   localparam int SEL_W     = $clog2(modsq_pkg::UPPER_WORDS);

   modsq_pkg::acc_state_t state;
   logic [SEL_W-1:0]      word_sel;
   logic                  last_word;
   modsq_pkg::word_t      cur_word;
   modsq_pkg::half_t      lo_half;
   modsq_pkg::half_t      hi_half;
   modsq_pkg::residue_t   lo_entry;
   modsq_pkg::residue_t   hi_entry;
   modsq_pkg::acc_t       acc  [modsq_pkg::NUM_ELEMENTS];
   modsq_pkg::digit_t     norm [modsq_pkg::NUM_ELEMENTS];

   assign last_word = (word_sel == SEL_W'(modsq_pkg::UPPER_WORDS - 1));
   assign cur_word  = prod_words[LOW_WORDS + int'(word_sel)];
   assign lo_half   = cur_word[modsq_pkg::LOOKUP_WIDTH-1:0];
   assign hi_half   = cur_word[modsq_pkg::WORD_LEN-1:modsq_pkg::LOOKUP_WIDTH];

   reduction_lut #(
      .MODULUS (MODULUS)
   ) u_lut (
      .word_sel (word_sel),
      .lo_half  (lo_half),
      .hi_half  (hi_half),
      .lo_entry (lo_entry),
      .hi_entry (hi_entry)
   );

   // Each digit keeps 16 bits and takes the spill of the digit below
   always_comb begin
      norm[0] = modsq_pkg::digit_t'(acc[0][modsq_pkg::WORD_LEN-1:0]);
      for (int i = 1; i < modsq_pkg::NUM_ELEMENTS; i++) begin
         norm[i] = modsq_pkg::digit_t'(acc[i][modsq_pkg::WORD_LEN-1:0]) +
                   modsq_pkg::digit_t'(acc[i-1][modsq_pkg::ACC_LEN-1:modsq_pkg::WORD_LEN]);
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= modsq_pkg::ACC_IDLE;
         word_sel <= '0;
         valid    <= 1'b0;
      end else begin
         valid <= 1'b0;
         case (state)
            modsq_pkg::ACC_IDLE: begin
               if (prod_ready) begin
                  state    <= modsq_pkg::ACC_LOOKUP;
                  word_sel <= '0;
               end
            end
            modsq_pkg::ACC_LOOKUP: begin
               if (last_word) begin
                  word_sel <= '0;
                  state    <= modsq_pkg::ACC_NORMALIZE;
               end else begin
                  word_sel <= word_sel + 1'b1;
               end
            end
            modsq_pkg::ACC_NORMALIZE: begin
               valid <= 1'b1;
               state <= modsq_pkg::ACC_IDLE;
            end
            default: state <= modsq_pkg::ACC_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == modsq_pkg::ACC_IDLE && prod_ready) begin
         // Low words already sit at digit weight
         for (int i = 0; i < modsq_pkg::NUM_ELEMENTS; i++) begin
            acc[i] <= modsq_pkg::acc_t'(prod_words[i]);
         end
      end else if (state == modsq_pkg::ACC_LOOKUP) begin
         for (int d = 0; d < modsq_pkg::RES_WORDS; d++) begin
            acc[d] <= acc[d] +
               modsq_pkg::acc_t'(lo_entry[d*modsq_pkg::WORD_LEN +: modsq_pkg::WORD_LEN]) +
               modsq_pkg::acc_t'(hi_entry[d*modsq_pkg::WORD_LEN +: modsq_pkg::WORD_LEN]);
         end
      end else if (state == modsq_pkg::ACC_NORMALIZE) begin
         sq_out <= norm;
      end
   end

endmodule

// File: src/modular_square_loop.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Iterated modular squarer, top level
// Squarer, word buffer and reduction run as a closed loop
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module modular_square_loop #(
   parameter modsq_pkg::residue_t MODULUS = modsq_pkg::MODULUS_DEFAULT
) (
   input  logic               clk,
   input  logic               rst,
   input  logic               start,
   input  modsq_pkg::digit_t  sq_in  [modsq_pkg::NUM_ELEMENTS],
   output modsq_pkg::digit_t  sq_out [modsq_pkg::NUM_ELEMENTS],
   output logic               valid
);

   logic                col_valid;
   logic                col_last;
   modsq_pkg::column_t  col_sum;
   modsq_pkg::word_t    prod_words [modsq_pkg::PROD_WORDS];
   logic                prod_ready;

   // sq_out and valid also return as the next operand and its load strobe
   square_column_gen u_squarer (
      .clk       (clk),
      .rst       (rst),
      .start     (start),
      .valid     (valid),
      .sq_in     (sq_in),
      .sq_out    (sq_out),
      .col_valid (col_valid),
      .col_last  (col_last),
      .col_sum   (col_sum)
   );

   product_column_buffer u_buffer (
      .clk        (clk),
      .rst        (rst),
      .col_valid  (col_valid),
      .col_last   (col_last),
      .col_sum    (col_sum),
      .prod_words (prod_words),
      .prod_ready (prod_ready)
   );

   reduction_accumulator #(
      .MODULUS (MODULUS)
   ) u_reduce (
      .clk        (clk),
      .rst        (rst),
      .prod_ready (prod_ready),
      .prod_words (prod_words),
      .sq_out     (sq_out),
      .valid      (valid)
   );

endmodule

// File: testbench/tb_modular_square_loop.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the iterated modular squarer
// Random operands checked against a wide-arithmetic model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module tb_modular_square_loop;

   localparam int NUM_EL   = modsq_pkg::NUM_ELEMENTS;
   localparam int DIG_LEN  = modsq_pkg::BIT_LEN;
   localparam int WORD_LEN = modsq_pkg::WORD_LEN;
   localparam int DIGITS_W = NUM_EL * DIG_LEN;
   localparam modsq_pkg::residue_t MODULUS = modsq_pkg::MODULUS_DEFAULT;

   // From the edge that samples start to the edge that raises valid
   localparam int FIRST_LATENCY = 18;
   // Squarer reloads on the edge after valid, one extra cycle per turn
   localparam int LOOP_PERIOD   = 19;
   localparam int WAIT_LIMIT    = 40;

   logic                clk;
   logic                rst;
   logic                start;
   modsq_pkg::digit_t   sq_in  [NUM_EL];
   modsq_pkg::digit_t   sq_out [NUM_EL];
   logic                valid;
   logic [DIGITS_W-1:0] out_packed;
   logic [DIGITS_W-1:0] operand;
   modsq_pkg::residue_t expected;

   modular_square_loop #(
      .MODULUS (MODULUS)
   ) uut (
      .clk    (clk),
      .rst    (rst),
      .start  (start),
      .sq_in  (sq_in),
      .sq_out (sq_out),
      .valid  (valid)
   );

   initial clk = 1'b0;
   always #5 clk = ~clk;

   always_comb begin
      for (int i = 0; i < NUM_EL; i++) begin
         out_packed[i*DIG_LEN +: DIG_LEN] = sq_out[i];
      end
   end

   // Value of the redundant digits, digit i weighted by 2^(16i)
   function automatic logic [95:0] digits_value(input logic [DIGITS_W-1:0] d);
      logic [95:0] v;
      v = '0;
      for (int i = 0; i < NUM_EL; i++) begin
         v = v + (96'(d[i*DIG_LEN +: DIG_LEN]) << (WORD_LEN * i));
      end
      return v;
   endfunction

   function automatic modsq_pkg::residue_t residue_of(input logic [95:0] v);
      logic [95:0] r;
      r = v % {32'b0, MODULUS};
      return r[63:0];
   endfunction

   function automatic modsq_pkg::residue_t square_mod(input logic [95:0] v);
      logic [191:0] w;
      logic [191:0] sq;
      logic [191:0] r;
      w  = {96'b0, v};
      sq = w * w;
      r  = sq % {128'b0, MODULUS};
      return r[63:0];
   endfunction

   function automatic logic [DIGITS_W-1:0] random_operand();
      logic [DIGITS_W-1:0] p;
      logic [31:0]         r;
      p = '0;
      for (int i = 0; i < NUM_EL; i++) begin
         r = $urandom;
         p[i*DIG_LEN +: DIG_LEN] = r[DIG_LEN-1:0];
      end
      return p;
   endfunction

   task automatic check_value(input string name, input logic [63:0] actual,
                              input logic [63:0] exp_val);
      if (actual !== exp_val) begin
         $display("Fail at %0t: %s is %h, expected %h", $time, name, actual, exp_val);
         $display("CHECKS FAILED");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   task automatic drive_operand(input logic [DIGITS_W-1:0] p);
      for (int i = 0; i < NUM_EL; i++) begin
         sq_in[i] = p[i*DIG_LEN +: DIG_LEN];
      end
   endtask

   task automatic apply_reset();
      rst   = 1'b1;
      start = 1'b0;
      repeat (3) @(negedge clk);
      rst = 1'b0;
      check_value("valid", 64'(valid), 64'd0);
      check_value("col_valid", 64'(uut.col_valid), 64'd0);
      check_value("prod_ready", 64'(uut.prod_ready), 64'd0);
   endtask

   // One-cycle start pulse, model result kept for the next check
   task automatic start_square(input logic [DIGITS_W-1:0] p);
      drive_operand(p);
      start = 1'b1;
      @(negedge clk);
      start    = 1'b0;
      expected = square_mod(digits_value(p));
   endtask

   // Optionally pulses start with new digits at cycle inject_at
   task automatic wait_for_valid(input int inject_at, output int cycles);
      bit seen;
      seen   = 1'b0;
      cycles = 0;
      while (!seen && cycles < WAIT_LIMIT) begin
         @(negedge clk);
         cycles++;
         start = (cycles == inject_at);
         if (start) begin
            drive_operand(random_operand());
         end
         seen = valid;
      end
      if (!seen) begin
         $display("Timeout: valid did not rise within %0d cycles at %0t", WAIT_LIMIT, $time);
         $display("CHECKS FAILED");
         $fatal(1, "no result from the DUT");
      end
   endtask

   task automatic check_result(input int latency, input int inject_at);
      int                  cycles;
      modsq_pkg::residue_t got;
      wait_for_valid(inject_at, cycles);
      check_value("valid latency", 64'(cycles), 64'(latency));
      got = residue_of(digits_value(out_packed));
      check_value("sq_out mod MODULUS", got, expected);
      // Next turn of the loop squares this residue
      expected = square_mod({32'b0, expected});
   endtask

   initial begin
      void'($urandom(55));
      rst   = 1'b1;
      start = 1'b0;
      drive_operand('0);
      apply_reset();

      // Nothing happens without start
      for (int i = 0; i < 50; i++) begin
         @(negedge clk);
         check_value("valid", 64'(valid), 64'd0);
      end

      operand = random_operand();
      start_square(operand);
      check_result(FIRST_LATENCY, 0);
      for (int n = 0; n < 8; n++) begin
         check_result(LOOP_PERIOD, 0);
      end

      // Start pulses while the loop runs must not disturb it
      for (int n = 0; n < 4; n++) begin
         check_result(LOOP_PERIOD, 2 + 5 * n);
      end

      for (int t = 0; t < 20; t++) begin
         apply_reset();
         if (t % 5 == 0) begin
            operand = {NUM_EL{17'h1FFFF}};
         end else begin
            operand = random_operand();
         end
         start_square(operand);
         check_result(FIRST_LATENCY, 0);
         check_result(LOOP_PERIOD, 0);
         check_result(LOOP_PERIOD, 0);
      end

      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

// File: vlog.f
src/modsq_pkg.sv
src/square_column_gen.sv
src/product_column_buffer.sv
src/reduction_lut.sv
src/reduction_accumulator.sv
src/modular_square_loop.sv
testbench/tb_modular_square_loop.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it.
# The exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f \
   --top-module tb_modular_square_loop -o sim_tb \
   && ./obj_dir/sim_tb \
   || { echo "simulation failed"; exit 1; }

exit 0
